// ==== Makefile ====
# Verilator build and run of the attention coefficient testbench
TOP := gat_attn_tb

.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/1ps --top-module $(TOP) -f gat_attn.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== attn_dot/attn_dot.sv ====
/*
 * Dot product stage. Keeps the attention vector from the last load item
 * and, for each node item, forms the source and neighbour dot products.
 * One registered multiply stage plus a registered adder tree, 4 cycles.
 */

`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module attn_dot (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      item_vld_i,
  input  gat_types_pkg::pipe_item_t item_i,
  output logic                      dot_vld_o,
  output gat_types_pkg::dot_res_t   dot_o
);

  import gat_ctrl_pkg::*;
  import gat_types_pkg::*;

  localparam int N     = `GAT_NUM_FEAT;
  localparam int LV    = `GAT_TREE_LEVELS;
  localparam int DW    = `GAT_DOT_WIDTH;
  localparam int NODES = 2 * N - 1;

  attn_vec_t           attn_q;
  attn_half_t          half_w [2];
  logic signed [DW-1:0] tree_q [2][NODES];
  logic [LV:0]         vld_q;
  logic [LV:0]         flag_q;
  logic                node_in;
  logic                load_in;

  assign node_in = item_vld_i && (item_i.op == OP_NODE);
  assign load_in = item_vld_i && (item_i.op == OP_LOAD_ATTN);

  // ====================
  // attention vector
  // ====================
  always_ff @(posedge clk) begin
    if (load_in) begin
      attn_q <= item_i.attn;
    end
  end

  // index 0 is the source half, 1 the neighbour half
  assign half_w[0] = attn_q.src;
  assign half_w[1] = attn_q.nbr;

  // ====================
  // multiply and reduce
  // ====================
  // tree_q holds all levels back to back with the leaves first and the root last
  for (genvar h = 0; h < 2; h++) begin : g_half
    for (genvar k = 0; k < N; k++) begin : g_mul
      always_ff @(posedge clk) begin
        if (node_in) begin
          tree_q[h][k] <= $signed(half_w[h][k]) * $signed(item_i.wh[k]);
        end
      end
    end

    for (genvar l = 1; l <= LV; l++) begin : g_lvl
      localparam int PRV = 2 * N - ((2 * N) >> (l - 1));
      localparam int CUR = 2 * N - ((2 * N) >> l);
      for (genvar k = 0; k < (N >> l); k++) begin : g_add
        always_ff @(posedge clk) begin
          tree_q[h][CUR + k] <= tree_q[h][PRV + 2 * k] + tree_q[h][PRV + 2 * k + 1];
        end
      end
    end
  end

  // valid follows the data through multiply and every tree level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[LV-1:0], node_in};
    end
  end

  always_ff @(posedge clk) begin
    flag_q <= {flag_q[LV-1:0], item_i.src_flag};
  end

  assign dot_vld_o = vld_q[LV];
  assign dot_o = '{
    src_flag: flag_q[LV],
    src_dot:  tree_q[0][NODES-1],
    nbr_dot:  tree_q[1][NODES-1]
  };

endmodule

`default_nettype wire

// ==== common/gat_cfg.svh ====
/*
 * Sizes and constants for the graph-attention coefficient pipeline.
 * Include this header wherever a width, depth or shift is needed.
 * All RTL modules take their sizes from here.
 */

`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// ====================
// node and vector sizes
// ====================
`define GAT_NUM_FEAT     8
`define GAT_TREE_LEVELS  3

// signed operand widths
`define GAT_A_WIDTH      8
`define GAT_WH_WIDTH     12
`define GAT_DOT_WIDTH    24

// ====================
// coefficient output
// ====================
`define GAT_COEF_WIDTH   8
`define GAT_COEF_SHIFT   8

// also the initial credit count at the ingress
`define GAT_FIFO_DEPTH   8

`endif

// ==== common/gat_ctrl_pkg.sv ====
/*
 * Control encodings of the attention pipeline.
 * Holds the host opcodes and the states of the four-phase receiver.
 */

`default_nettype none

package gat_ctrl_pkg;

  // host command opcodes
  typedef enum logic [1:0] {
    OP_NOP       = 2'd0,
    OP_LOAD_ATTN = 2'd1,
    OP_NODE      = 2'd2
  } gat_op_e;

  // four-phase receiver states
  typedef enum logic [1:0] {
    HS_IDLE      = 2'd0,
    HS_ACK       = 2'd1,
    HS_WAIT_DROP = 2'd2
  } hs_state_e;

endpackage

`default_nettype wire

// ==== common/gat_types_pkg.sv ====
/*
 * Packed data types of the attention pipeline: weight vectors, node
 * features, host commands, pipeline items and dot product results.
 * Opcode fields use the enum from the control package.
 */

`default_nettype none

`include "gat_cfg.svh"

package gat_types_pkg;

  // one signed attention weight, one half of the vector
  typedef logic signed [`GAT_A_WIDTH-1:0] attn_w_t;
  typedef attn_w_t [`GAT_NUM_FEAT-1:0] attn_half_t;

  typedef struct packed {
    attn_half_t src;
    attn_half_t nbr;
  } attn_vec_t;

  // transformed node features
  typedef logic signed [`GAT_WH_WIDTH-1:0] wh_elem_t;
  typedef wh_elem_t [`GAT_NUM_FEAT-1:0] wh_vec_t;

  // command as presented on the host link
  typedef struct packed {
    gat_ctrl_pkg::gat_op_e op;
    logic                  src_flag;
    wh_vec_t               wh;
    attn_vec_t             attn;
  } host_cmd_t;

  // item issued by the ingress into the dot stage
  typedef struct packed {
    gat_ctrl_pkg::gat_op_e op;
    logic                  src_flag;
    wh_vec_t               wh;
    attn_vec_t             attn;
  } pipe_item_t;

  typedef struct packed {
    logic                            src_flag;
    logic signed [`GAT_DOT_WIDTH-1:0] src_dot;
    logic signed [`GAT_DOT_WIDTH-1:0] nbr_dot;
  } dot_res_t;

endpackage

`default_nettype wire

// ==== design/coef_act.sv ====
/*
 * Coefficient activation. Remembers the source dot of the current subgraph
 * and turns each record into an 8-bit coefficient: ReLU of the sum,
 * shifted right and saturated. One register stage.
 */

`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module coef_act (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           dot_vld_i,
  input  gat_types_pkg::dot_res_t        dot_i,
  output logic                           coef_vld_o,
  output logic [`GAT_COEF_WIDTH-1:0]     coef_o
);

  localparam int DW = `GAT_DOT_WIDTH;
  localparam int CW = `GAT_COEF_WIDTH;
  localparam int SW = DW + 1;

  logic signed [DW-1:0] src_dot_q;
  logic signed [DW-1:0] src_dot_sel;
  logic signed [SW-1:0] sum;
  logic [SW-1:0]        relu;
  logic [SW-1:0]        shifted;
  logic [CW-1:0]        coef_d;

  always_comb begin
    // a source record uses its own dot right away
    src_dot_sel = dot_i.src_flag ? $signed(dot_i.src_dot) : src_dot_q;
    sum         = SW'(src_dot_sel) + SW'($signed(dot_i.nbr_dot));
    relu        = sum[SW-1] ? '0 : SW'(sum);
    shifted     = relu >> `GAT_COEF_SHIFT;
    coef_d      = (|shifted[SW-1:CW]) ? '1 : shifted[CW-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_vld_o <= 1'b0;
    end else begin
      coef_vld_o <= dot_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (dot_vld_i) begin
      coef_o <= coef_d;
      if (dot_i.src_flag) begin
        src_dot_q <= dot_i.src_dot;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/coef_fifo.sv ====
/*
 * Output FIFO for coefficients. Written on every valid from the activation
 * stage and popped by the consumer with valid/ready. Each pop sends a
 * slot-freed pulse back to the ingress credit counter.
 */

`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module coef_fifo (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_vld_i,
  input  logic [`GAT_COEF_WIDTH-1:0] wr_data_i,
  output logic                       coef_vld_o,
  output logic [`GAT_COEF_WIDTH-1:0] coef_o,
  input  logic                       coef_rdy_i,
  output logic                       slot_free_o
);

  localparam int DEPTH = `GAT_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = `GAT_COEF_WIDTH;

  logic [CW-1:0] mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          pop;

  assign coef_vld_o = (count_q != '0);
  assign coef_o     = mem[rd_ptr_q];
  assign pop        = coef_vld_o && coef_rdy_i;

  // ingress credits keep the writes in bounds
  always_ff @(posedge clk) begin
    if (wr_vld_i) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      slot_free_o <= 1'b0;
    end else begin
      if (wr_vld_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q     <= count_q + (AW + 1)'(wr_vld_i) - (AW + 1)'(pop);
      slot_free_o <= pop;
    end
  end

endmodule

`default_nettype wire

// ==== design/gat_attn_top.sv ====
/*
 * Top level of the attention coefficient pipeline.
 * Host link in, ingress, dot products, activation, output FIFO out.
 */

`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module gat_attn_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,
  input  gat_types_pkg::host_cmd_t   cmd_i,
  output logic                       ack_o,
  output logic                       coef_vld_o,
  output logic [`GAT_COEF_WIDTH-1:0] coef_o,
  input  logic                       coef_rdy_i
);

  import gat_types_pkg::*;

  pipe_item_t                 item;
  dot_res_t                   dot;
  logic                       item_vld;
  logic                       dot_vld;
  logic                       coef_vld;
  logic [`GAT_COEF_WIDTH-1:0] coef;
  logic                       slot_free;

  // ====================
  // pipeline stages
  // ====================
  gat_ingress u_ingress (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .cmd_i       (cmd_i),
    .ack_o       (ack_o),
    .slot_free_i (slot_free),
    .item_vld_o  (item_vld),
    .item_o      (item)
  );

  attn_dot u_attn_dot (
    .clk        (clk),
    .rst_n      (rst_n),
    .item_vld_i (item_vld),
    .item_i     (item),
    .dot_vld_o  (dot_vld),
    .dot_o      (dot)
  );

  coef_act u_coef_act (
    .clk        (clk),
    .rst_n      (rst_n),
    .dot_vld_i  (dot_vld),
    .dot_i      (dot),
    .coef_vld_o (coef_vld),
    .coef_o     (coef)
  );

  // slot_free closes the credit loop back to the ingress
  coef_fifo u_coef_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_vld_i    (coef_vld),
    .wr_data_i   (coef),
    .coef_vld_o  (coef_vld_o),
    .coef_o      (coef_o),
    .coef_rdy_i  (coef_rdy_i),
    .slot_free_o (slot_free)
  );

endmodule

`default_nettype wire

// ==== design/gat_ingress.sv ====
/*
 * Host-side receiver. Runs the four-phase req/ack protocol and turns each
 * accepted command into a one-cycle pipeline item. Node commands consume
 * a credit, and slot-freed pulses from the output FIFO return them.
 */

`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module gat_ingress (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  gat_types_pkg::host_cmd_t cmd_i,
  output logic                     ack_o,
  input  logic                     slot_free_i,
  output logic                     item_vld_o,
  output gat_types_pkg::pipe_item_t item_o
);

  import gat_ctrl_pkg::*;

  localparam int DEPTH = `GAT_FIFO_DEPTH;
  localparam int CRW   = $clog2(DEPTH + 1);

  hs_state_e      state_q;
  logic [CRW-1:0] credit_q;
  logic           is_node;
  logic           accept;
  logic           take_credit;

  // loads and nops never wait for a credit
  assign is_node     = (cmd_i.op == OP_NODE);
  assign accept      = (state_q == HS_IDLE) && req_i && (!is_node || (credit_q != '0));
  assign take_credit = accept && is_node;

  // ====================
  // handshake FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= HS_IDLE;
      ack_o      <= 1'b0;
      item_vld_o <= 1'b0;
    end else begin
      item_vld_o <= 1'b0;
      case (state_q)
        HS_IDLE: begin
          if (accept) begin
            state_q    <= HS_ACK;
            ack_o      <= 1'b1;
            item_vld_o <= 1'b1;
          end
        end
        HS_ACK: begin
          // hold ack until the host lets go of req
          if (!req_i) begin
            state_q <= HS_WAIT_DROP;
            ack_o   <= 1'b0;
          end
        end
        HS_WAIT_DROP: begin
          // ack stays low a full cycle before the next request
          state_q <= HS_IDLE;
        end
        default: begin
          state_q <= HS_IDLE;
          ack_o   <= 1'b0;
        end
      endcase
    end
  end

  // one credit per free FIFO slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= CRW'(DEPTH);
    end else begin
      credit_q <= credit_q - CRW'(take_credit) + CRW'(slot_free_i);
    end
  end

  // command capture on the accepting edge
  always_ff @(posedge clk) begin
    if (accept) begin
      item_o.op       <= cmd_i.op;
      item_o.src_flag <= cmd_i.src_flag;
      item_o.wh       <= cmd_i.wh;
      item_o.attn     <= cmd_i.attn;
    end
  end

endmodule

`default_nettype wire

// ==== dv/gat_attn_golden.txt ====
// record count, then one record per line
// opcode src_flag wh[7..0] attn{src[7..0],nbr[7..0]} expected_coef
13
1 0 0 02020202020202020101010101010101 0
2 1 040040040040040040040040 0 06
2 0 100100100100100100100100 0 0c
2 0 001002003004005006007008 0 04
2 0 f00f00f00f00f00f00f00f00 0 00
2 0 7ff7ff7ff7ff7ff7ff7ff7ff 0 43
2 1 080080080080080080080080 0 0c
2 0 200200200200200200200200 0 18
2 0 7ff8017ff8017ff8017ff801 0 08
2 0 ffffffffffffffffffffffff 0 07
1 0 0 7f7f7f7f7f7f7f7f4000000000000001 0
2 1 010010010010010010010010 0 43
2 0 7ff7ff7ff7ff7ff7ff7ff7ff 0 ff
2 0 800800800800800800800800 0 00
2 0 008008008008008008008008 0 41
2 0 000000000000000000000100 0 40
2 0 020020020020020020020020 0 47
2 1 fe0fe0fe0fe0fe0fe0fe0fe0 0 00
2 0 200200200200200200200200 0 03

// ==== dv/gat_attn_tb.sv ====
/*
 * Testbench for the attention coefficient pipeline. Replays the golden
 * command stream over the four-phase host link and checks each popped
 * coefficient in order. The consumer holds off for a long stretch first,
 * then stalls at random.
 */

`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module gat_attn_tb;

  import gat_ctrl_pkg::*;
  import gat_types_pkg::*;

  localparam int MEM_WORDS   = 128;
  localparam int REC_WORDS   = 5;
  localparam int ACK_TIMEOUT = 1000;
  localparam int END_TIMEOUT = 2000;
  localparam int LONG_STALL  = 200;
  localparam int DEPTH       = `GAT_FIFO_DEPTH;

  logic                       clk;
  logic                       rst_n;
  logic                       req_i;
  host_cmd_t                  cmd_i;
  logic                       ack_o;
  logic                       coef_vld_o;
  logic [`GAT_COEF_WIDTH-1:0] coef_o;
  logic                       coef_rdy_i;

  logic [127:0] golden_mem [MEM_WORDS];
  int           exp_q [$];
  int           accepted;
  int           popped;
  int           max_pending;
  int           blocked_cycles;

  gat_attn_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .cmd_i      (cmd_i),
    .ack_o      (ack_o),
    .coef_vld_o (coef_vld_o),
    .coef_o     (coef_o),
    .coef_rdy_i (coef_rdy_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // checking helpers
  // ====================
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      stop_with_failure($sformatf("Fail %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  // one full four-phase transfer that starts right after a rising edge
  task automatic send_cmd(input host_cmd_t cmd);
    int waited;
    cmd_i <= cmd;
    req_i <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > ACK_TIMEOUT) begin
        stop_with_failure("timeout waiting for ack to rise");
      end
    end while (!ack_o);
    req_i <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > ACK_TIMEOUT) begin
        stop_with_failure("timeout waiting for ack to drop");
      end
    end while (ack_o);
  endtask

  // ====================
  // consumer and monitor
  // ====================
  // outputs are sampled before the edge updates land
  initial begin : consumer
    int   pending;
    int   cycle_cnt;
    logic ack_prev;
    void'($urandom(48729));
    coef_rdy_i     = 1'b0;
    accepted       = 0;
    popped         = 0;
    max_pending    = 0;
    blocked_cycles = 0;
    cycle_cnt      = 0;
    ack_prev       = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        if (coef_vld_o && coef_rdy_i) begin
          if (exp_q.size() == 0) begin
            stop_with_failure("a coefficient came out with none left to expect");
          end
          compare_value($sformatf("coef_%0d", popped), exp_q.pop_front(), int'(coef_o));
          popped++;
        end
        if (ack_o && !ack_prev && cmd_i.op == OP_NODE) begin
          accepted++;
        end
        ack_prev = ack_o;
        pending  = accepted - popped;
        if (pending > max_pending) begin
          max_pending = pending;
        end
        if (pending > DEPTH) begin
          stop_with_failure("more nodes were accepted than the FIFO can hold");
        end
        // node request waiting while every slot is taken
        if (req_i && !ack_o && cmd_i.op == OP_NODE && pending == DEPTH) begin
          blocked_cycles++;
        end
        cycle_cnt++;
        if (cycle_cnt < LONG_STALL) begin
          coef_rdy_i <= 1'b0;
        end else begin
          coef_rdy_i <= (($urandom % 4) != 32'd0);
        end
      end
    end
  end

  // ====================
  // host side
  // ====================
  initial begin : host
    host_cmd_t cmd;
    int        num_recs;
    int        base;
    int        waited;
    rst_n = 1'b0;
    req_i = 1'b0;
    cmd_i = '0;
    $readmemh("dv/gat_attn_golden.txt", golden_mem);
    num_recs = int'(golden_mem[0][31:0]);
    for (int i = 0; i < num_recs; i++) begin
      base = 1 + REC_WORDS * i;
      if (golden_mem[base][1:0] == OP_NODE) begin
        exp_q.push_back(int'(golden_mem[base + 4][7:0]));
      end
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    compare_value("reset_ack", 0, int'(ack_o));
    compare_value("reset_coef_vld", 0, int'(coef_vld_o));

    for (int i = 0; i < num_recs; i++) begin
      base         = 1 + REC_WORDS * i;
      cmd.op       = gat_op_e'(golden_mem[base][1:0]);
      cmd.src_flag = golden_mem[base + 1][0];
      cmd.wh       = golden_mem[base + 2][95:0];
      cmd.attn     = golden_mem[base + 3];
      send_cmd(cmd);
    end

    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > END_TIMEOUT) begin
        stop_with_failure("timeout waiting for the remaining coefficients");
      end
    end
    @(posedge clk);
    compare_value("fifo_empty_at_end", 0, int'(coef_vld_o));
    compare_value("fifo_fill", DEPTH, max_pending);
    compare_value("ack_withheld", 1, int'(blocked_cycles > 0));
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== gat_attn.f ====
+incdir+common
common/gat_ctrl_pkg.sv
common/gat_types_pkg.sv
design/gat_ingress.sv
attn_dot/attn_dot.sv
design/coef_act.sv
design/coef_fifo.sv
design/gat_attn_top.sv
dv/gat_attn_tb.sv
